// File: sources.f
+incdir+hw
hw/cache_pkg.sv
hw/line_memory.sv
hw/data_cache.sv
hw/cache_subsystem.sv
dv/tb_cache_subsystem.sv

// File: Bender.yml
package:
  name: cache_subsystem

export_include_dirs:
  - hw

sources:
  - files:
      - hw/cache_pkg.sv
      - hw/line_memory.sv
      - hw/data_cache.sv
      - hw/cache_subsystem.sv
  - target: test
    files:
      - dv/tb_cache_subsystem.sv

// File: dv/tb_cache_subsystem.sv
`include "cache_consts.svh"

module tb_cache_subsystem;

    localparam int CLK_PERIOD   = 10;
    localparam int RESET_CYCLES = 16;
    localparam int MEM_BYTES    = `MEM_N_LINES * `CACHE_LINE_BYTES;
    localparam int WORST_MISS   = 2 * (`MEM_LATENCY + 3);
    localparam int MAX_CYCLES   = 2 * WORST_MISS;
    localparam int N_RANDOM     = 200;
    localparam int N_DIRECTED   = 23;
    localparam int N_ACCESSES   = N_DIRECTED + N_RANDOM;
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + N_ACCESSES * 2 * WORST_MISS + 200;

    logic               clk;
    logic               rstn;
    logic               cpu_req;
    logic               cpu_wr;
    cache_pkg::addr_t   cpu_addr;
    cache_pkg::word_t   cpu_wdata;
    cache_pkg::strb_t   cpu_wstrb;
    cache_pkg::size_t   cpu_size;
    logic               cpu_ready;
    logic               cpu_rvalid;
    cache_pkg::word_t   cpu_rdata;

    logic [7:0]         shadow [MEM_BYTES];         // Byte image of memory
    int                 cached_line [`CACHE_N_LINES]; // Line number per index or -1
    logic [31:0]        lfsr_state;
    int                 errors;
    int                 checks;
    int                 tests_run;

    cache_subsystem DUT (
        .clk        (clk),
        .rstn       (rstn),
        .cpu_req    (cpu_req),
        .cpu_wr     (cpu_wr),
        .cpu_addr   (cpu_addr),
        .cpu_wdata  (cpu_wdata),
        .cpu_wstrb  (cpu_wstrb),
        .cpu_size   (cpu_size),
        .cpu_ready  (cpu_ready),
        .cpu_rvalid (cpu_rvalid),
        .cpu_rdata  (cpu_rdata)
    );

    always #(CLK_PERIOD/2) clk = ~clk;

    task automatic check_word(input string name, input cache_pkg::word_t exp,
                              input cache_pkg::word_t act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("** Error at %0t: %s expected %h, got %h", $time, name, exp, act);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("** Error at %0t: %s expected %b, got %b", $time, name, exp, act);
        end
    endtask

    // Taps 32, 22, 2, 1
    function automatic logic lfsr_bit();
        logic fb;
        fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[30:0], lfsr_bit()};
        end
        return r;
    endfunction

    function automatic int size_bytes(input cache_pkg::size_t size);
        return (size >= `SIZE_WORD) ? 4 : (1 << size);
    endfunction

    // Naturally aligned and zero-extended
    function automatic cache_pkg::word_t expected_load(input cache_pkg::addr_t addr,
                                                      input cache_pkg::size_t size);
        int nbytes;
        int base;
        cache_pkg::word_t val;
        nbytes = size_bytes(size);
        base   = int'(addr % MEM_BYTES) & ~(nbytes - 1);
        val    = '0;
        for (int b = 0; b < nbytes; b++) begin
            val[b*8 +: 8] = shadow[base + b];
        end
        return val;
    endfunction

    function automatic void apply_store(input cache_pkg::addr_t addr,
                                        input cache_pkg::word_t wdata,
                                        input cache_pkg::strb_t wstrb,
                                        input cache_pkg::size_t size);
        cache_pkg::strb_t strb;
        int nbytes;
        int first;
        int base;
        nbytes = size_bytes(size);
        first  = int'(addr[1:0]) & ~(nbytes - 1);
        base   = int'(addr % MEM_BYTES) & ~3;
        strb   = wstrb;
        if (strb == '0) begin
            for (int b = 0; b < 4; b++) begin
                strb[b] = (b >= first) && (b < first + nbytes);
            end
        end
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
                shadow[base + b] = wdata[b*8 +: 8];
            end
        end
    endfunction

    // Issues one request and checks its data and timing
    task automatic access(input logic wr, input cache_pkg::addr_t addr,
                          input cache_pkg::word_t wdata, input cache_pkg::strb_t wstrb,
                          input cache_pkg::size_t size);
        int line_no;
        int idx;
        logic pred_hit;
        cache_pkg::word_t exp_data;
        int cycles;
        line_no  = int'(addr / `CACHE_LINE_BYTES);
        idx      = line_no % `CACHE_N_LINES;
        pred_hit = (cached_line[idx] == line_no);
        exp_data = expected_load(addr, size);
        @(posedge clk);
        cpu_req   <= 1'b1;
        cpu_wr    <= wr;
        cpu_addr  <= addr;
        cpu_wdata <= wdata;
        cpu_wstrb <= wstrb;
        cpu_size  <= size;
        @(posedge clk); // Accepting edge
        cpu_req <= 1'b0;
        @(negedge clk);
        check_bit("cpu_ready", 1'b0, cpu_ready);
        check_bit("cpu_rvalid", 1'b0, cpu_rvalid);
        @(negedge clk);
        check_bit("cpu_ready", pred_hit, cpu_ready); // Hits finish one cycle in
        cycles = 1;
        while (!cpu_ready && cycles <= MAX_CYCLES) begin
            check_bit("cpu_rvalid", 1'b0, cpu_rvalid);
            @(negedge clk);
            cycles++;
        end
        if (!cpu_ready) begin
            errors++;
            $display("Error at %0t: cpu_ready did not return within %0d cycles for address %h",
                     $time, MAX_CYCLES, addr);
        end else begin
            check_bit("cpu_rvalid", !wr, cpu_rvalid);
            if (!wr) begin
                check_word("cpu_rdata", exp_data, cpu_rdata);
            end
        end
        if (wr) begin
            apply_store(addr, wdata, wstrb, size);
        end
        cached_line[idx] = line_no;
    endtask

    task automatic report_test(input string name, input int errs_before);
        tests_run++;
        $display("%-22s %s (%0d errors)", name, (errors == errs_before) ? "ok" : "failed",
                 errors - errs_before);
    endtask

    task automatic reset_and_fresh_load();
        int errs_before;
        errs_before = errors;
        check_bit("cpu_ready", 1'b1, cpu_ready);
        check_bit("cpu_rvalid", 1'b0, cpu_rvalid);
        access(1'b0, 32'h3f0, '0, '0, `SIZE_WORD);
        @(negedge clk);
        check_bit("cpu_rvalid", 1'b0, cpu_rvalid); // Single pulse only
        report_test("reset_and_fresh_load", errs_before);
    endtask

    task automatic load_slices();
        int errs_before;
        errs_before = errors;
        access(1'b1, 32'h040, 32'ha1b2_c3d4, '0, `SIZE_WORD);
        for (int off = 0; off < 4; off++) begin
            access(1'b0, 32'h040 + off, '0, '0, `SIZE_BYTE);
        end
        access(1'b0, 32'h040, '0, '0, `SIZE_HALF);
        access(1'b0, 32'h042, '0, '0, `SIZE_HALF);
        access(1'b0, 32'h040, '0, '0, `SIZE_WORD);
        access(1'b0, 32'h044, '0, '0, `SIZE_WORD); // Untouched word of same line
        report_test("load_slices", errs_before);
    endtask

    task automatic partial_stores();
        int errs_before;
        errs_before = errors;
        for (int w = 0; w < 3; w++) begin
            access(1'b1, 32'h080 + 4*w, 32'h1122_3344, '0, `SIZE_WORD);
        end
        access(1'b1, 32'h081, 32'h0000_ee00, '0, `SIZE_BYTE);
        access(1'b1, 32'h086, 32'hbeef_0000, '0, `SIZE_HALF);
        access(1'b1, 32'h088, 32'h99aa_bbcc, 4'b1010, `SIZE_WORD);
        for (int w = 0; w < 3; w++) begin
            access(1'b0, 32'h080 + 4*w, '0, '0, `SIZE_WORD);
        end
        report_test("partial_stores", errs_before);
    endtask

    // Same index with a different tag
    task automatic dirty_eviction();
        int errs_before;
        errs_before = errors;
        access(1'b1, 32'h100, 32'hcafe_f00d, '0, `SIZE_WORD);
        access(1'b1, 32'h140, 32'h1234_5678, '0, `SIZE_WORD);
        access(1'b0, 32'h100, '0, '0, `SIZE_WORD);
        access(1'b0, 32'h140, '0, '0, `SIZE_WORD);
        report_test("dirty_eviction", errs_before);
    endtask

    task automatic random_traffic();
        int errs_before;
        logic wr;
        logic [2:0] k;
        logic [1:0] word_sel;
        logic [1:0] off;
        cache_pkg::size_t size;
        cache_pkg::word_t data;
        cache_pkg::strb_t strb;
        cache_pkg::addr_t addr;
        errs_before = errors;
        for (int i = 0; i < N_RANDOM; i++) begin
            wr       = rand_bits(1);
            k        = rand_bits(3);
            word_sel = rand_bits(2);
            size     = rand_bits(2);
            off      = rand_bits(2);
            data     = rand_bits(32);
            strb     = rand_bits(1) ? rand_bits(4) : '0;
            if (size == 2'd3) begin
                size = `SIZE_WORD;
            end
            off  = off & ~(size_bytes(size) - 1);
            strb = wr ? strb : '0;
            addr = (32 + 3*k) * `CACHE_LINE_BYTES + 4*word_sel + off; // Eight lines over four indices
            access(wr, addr, data, strb, size);
        end
        report_test("random_traffic", errs_before);
    endtask

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Timeout: simulation ran past %0d cycles without finishing", WATCHDOG_CYCLES);
        $display("TB FAILED");
        $finish;
    end

    initial begin
        clk        = 1'b0;
        rstn       = 1'b0;
        cpu_req    = 1'b0;
        cpu_wr     = 1'b0;
        cpu_addr   = '0;
        cpu_wdata  = '0;
        cpu_wstrb  = '0;
        cpu_size   = `SIZE_WORD;
        lfsr_state = 32'd88671;
        errors     = 0;
        checks     = 0;
        tests_run  = 0;
        for (int i = 0; i < MEM_BYTES; i++) begin
            shadow[i] = 8'h00;
        end
        for (int i = 0; i < `CACHE_N_LINES; i++) begin
            cached_line[i] = -1;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        rstn <= 1'b1;
        @(negedge clk);

        reset_and_fresh_load();
        load_slices();
        partial_stores();
        dirty_eviction();
        random_traffic();

        $display("Summary: %0d tests, %0d checks, %0d errors", tests_run, checks, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// File: hw/cache_subsystem.sv
`include "cache_consts.svh"

module cache_subsystem (
    input  logic                clk,
    input  logic                rstn,

    input  logic                cpu_req,
    input  logic                cpu_wr,
    input  cache_pkg::addr_t    cpu_addr,
    input  cache_pkg::word_t    cpu_wdata,
    input  cache_pkg::strb_t    cpu_wstrb,
    input  cache_pkg::size_t    cpu_size,
    output logic                cpu_ready,
    output logic                cpu_rvalid,
    output cache_pkg::word_t    cpu_rdata
);

    // Cache to backing memory
    logic                       mem_req;
    logic                       mem_we;
    cache_pkg::addr_t           mem_addr;
    cache_pkg::line_t           mem_wdata;
    logic                       mem_busy;
    logic                       mem_rvalid;
    cache_pkg::line_t           mem_rdata;

    data_cache u_cache (
        .clk        (clk),
        .rstn       (rstn),
        .cpu_req    (cpu_req),
        .cpu_wr     (cpu_wr),
        .cpu_addr   (cpu_addr),
        .cpu_wdata  (cpu_wdata),
        .cpu_wstrb  (cpu_wstrb),
        .cpu_size   (cpu_size),
        .cpu_ready  (cpu_ready),
        .cpu_rvalid (cpu_rvalid),
        .cpu_rdata  (cpu_rdata),
        .mem_req    (mem_req),
        .mem_we     (mem_we),
        .mem_addr   (mem_addr),
        .mem_wdata  (mem_wdata),
        .mem_busy   (mem_busy),
        .mem_rvalid (mem_rvalid),
        .mem_rdata  (mem_rdata)
    );

    line_memory #(
        .LATENCY    (`MEM_LATENCY)
    ) u_mem (
        .clk        (clk),
        .rstn       (rstn),
        .mem_req    (mem_req),
        .mem_we     (mem_we),
        .mem_addr   (mem_addr),
        .mem_wdata  (mem_wdata),
        .mem_busy   (mem_busy),
        .mem_rvalid (mem_rvalid),
        .mem_rdata  (mem_rdata)
    );

endmodule

// File: hw/data_cache.sv
`include "cache_consts.svh"

module data_cache (
    input  logic                    clk,
    input  logic                    rstn,

    input  logic                    cpu_req,
    input  logic                    cpu_wr,      // 1 = store
    input  cache_pkg::addr_t        cpu_addr,
    input  cache_pkg::word_t        cpu_wdata,
    input  cache_pkg::strb_t        cpu_wstrb,   // Zero means derive from size
    input  cache_pkg::size_t        cpu_size,
    output logic                    cpu_ready,
    output logic                    cpu_rvalid,
    output cache_pkg::word_t        cpu_rdata,

    output logic                    mem_req,
    output logic                    mem_we,
    output cache_pkg::addr_t        mem_addr,    // Line aligned
    output cache_pkg::line_t        mem_wdata,
    input  logic                    mem_busy,    // Doubles as acknowledge
    input  logic                    mem_rvalid,
    input  cache_pkg::line_t        mem_rdata
);

    localparam int OFFSET_BITS = $clog2(`CACHE_LINE_BYTES);
    localparam int INDEX_BITS  = $clog2(`CACHE_N_LINES);
    localparam int WORD_BITS   = OFFSET_BITS - 2;

    cache_pkg::cache_state_e state;

    // Per-line storage and status bits
    cache_pkg::tag_t            tag_array  [`CACHE_N_LINES];
    cache_pkg::line_t           data_array [`CACHE_N_LINES];
    logic [`CACHE_N_LINES-1:0]  valid_array;
    logic [`CACHE_N_LINES-1:0]  dirty_array;

    // Latched CPU request
    logic                       req_wr;
    cache_pkg::addr_t           req_addr;
    cache_pkg::word_t           req_wdata;
    cache_pkg::strb_t           req_wstrb;
    cache_pkg::size_t           req_size;

    cache_pkg::index_t          req_index;
    cache_pkg::tag_t            req_tag;
    logic [WORD_BITS-1:0]       req_word;
    cache_pkg::addr_t           req_line_addr;
    cache_pkg::addr_t           victim_addr;

    logic                       hit;
    logic                       victim_dirty;
    logic                       accept;
    logic                       lookup_hit;
    logic                       lookup_miss;
    logic                       wb_done;
    logic                       fill_done;

    function automatic cache_pkg::strb_t size_strb(
        input logic [1:0]       byte_off,
        input cache_pkg::size_t size
    );
        cache_pkg::strb_t strb;
        case (size)
            `SIZE_BYTE: strb = 4'b0001 << byte_off;
            `SIZE_HALF: strb = byte_off[1] ? 4'b1100 : 4'b0011;
            default:    strb = 4'b1111;
        endcase
        return strb;
    endfunction

    // Zero-extended load slice out of a line
    function automatic cache_pkg::word_t load_extract(
        input cache_pkg::line_t     line,
        input logic [WORD_BITS-1:0] word_sel,
        input logic [1:0]           byte_off,
        input cache_pkg::size_t     size
    );
        cache_pkg::word_t word;
        cache_pkg::word_t result;
        word = line[word_sel*32 +: 32];
        case (size)
            `SIZE_BYTE: result = {24'd0, word[{byte_off, 3'b000} +: 8]};
            `SIZE_HALF: result = {16'd0, word[{byte_off[1], 4'b0000} +: 16]};
            default:    result = word;
        endcase
        return result;
    endfunction

    function automatic cache_pkg::line_t store_merge(
        input cache_pkg::line_t     line,
        input logic [WORD_BITS-1:0] word_sel,
        input cache_pkg::word_t     wdata,
        input cache_pkg::strb_t     wstrb
    );
        cache_pkg::line_t merged;
        merged = line;
        for (int b = 0; b < 4; b++) begin
            if (wstrb[b]) begin
                merged[word_sel*32 + b*8 +: 8] = wdata[b*8 +: 8];
            end
        end
        return merged;
    endfunction

    assign req_index     = req_addr[OFFSET_BITS +: INDEX_BITS];
    assign req_tag       = req_addr[`CACHE_ADDR_WIDTH-1 : OFFSET_BITS+INDEX_BITS];
    assign req_word      = req_addr[OFFSET_BITS-1:2];
    assign req_line_addr = {req_addr[`CACHE_ADDR_WIDTH-1:OFFSET_BITS], {OFFSET_BITS{1'b0}}};
    assign victim_addr   = {tag_array[req_index], req_index, {OFFSET_BITS{1'b0}}};

    assign hit          = valid_array[req_index] && (tag_array[req_index] == req_tag);
    assign victim_dirty = valid_array[req_index] && dirty_array[req_index];

    assign accept      = (state == cache_pkg::CS_IDLE) && cpu_req;
    assign lookup_hit  = (state == cache_pkg::CS_LOOKUP) && hit;
    assign lookup_miss = (state == cache_pkg::CS_LOOKUP) && !hit;
    assign wb_done     = (state == cache_pkg::CS_WRITEBACK) && !mem_busy && !mem_req;
    assign fill_done   = (state == cache_pkg::CS_REFILL) && mem_rvalid;

    assign cpu_ready = (state == cache_pkg::CS_IDLE);

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state       <= cache_pkg::CS_IDLE;
            valid_array <= '0;
            dirty_array <= '0;
            cpu_rvalid  <= 1'b0;
            mem_req     <= 1'b0;
        end else begin
            cpu_rvalid <= 1'b0;
            case (state)
                cache_pkg::CS_IDLE: begin
                    if (cpu_req) begin
                        state <= cache_pkg::CS_LOOKUP;
                    end
                end
                cache_pkg::CS_LOOKUP: begin
                    if (hit) begin
                        cpu_rvalid <= !req_wr;
                        if (req_wr) begin
                            dirty_array[req_index] <= 1'b1;
                        end
                        state <= cache_pkg::CS_IDLE;
                    end else begin
                        mem_req <= 1'b1;
                        state   <= victim_dirty ? cache_pkg::CS_WRITEBACK
                                                : cache_pkg::CS_REFILL;
                    end
                end
                cache_pkg::CS_WRITEBACK: begin
                    if (mem_busy) begin
                        mem_req <= 1'b0; // Acknowledged
                    end
                    if (wb_done) begin
                        mem_req <= 1'b1; // Now fetch the new line
                        state   <= cache_pkg::CS_REFILL;
                    end
                end
                cache_pkg::CS_REFILL: begin
                    if (mem_busy) begin
                        mem_req <= 1'b0;
                    end
                    if (mem_rvalid) begin
                        valid_array[req_index] <= 1'b1;
                        dirty_array[req_index] <= req_wr; // Allocated store dirties the line
                        cpu_rvalid             <= !req_wr;
                        state                  <= cache_pkg::CS_IDLE;
                    end
                end
                default: begin
                    state <= cache_pkg::CS_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            req_wr    <= cpu_wr;
            req_addr  <= cpu_addr;
            req_wdata <= cpu_wdata;
            req_size  <= cpu_size;
            req_wstrb <= (cpu_wstrb != '0) ? cpu_wstrb : size_strb(cpu_addr[1:0], cpu_size);
        end

        if (lookup_hit) begin
            if (req_wr) begin
                data_array[req_index] <= store_merge(data_array[req_index], req_word,
                                                     req_wdata, req_wstrb);
            end else begin
                cpu_rdata <= load_extract(data_array[req_index], req_word,
                                          req_addr[1:0], req_size);
            end
        end

        if (lookup_miss) begin
            mem_we    <= victim_dirty;
            mem_addr  <= victim_dirty ? victim_addr : req_line_addr;
            mem_wdata <= data_array[req_index];
        end

        if (wb_done) begin
            mem_we   <= 1'b0;
            mem_addr <= req_line_addr;
        end

        if (fill_done) begin
            tag_array[req_index] <= req_tag;
            if (req_wr) begin
                data_array[req_index] <= store_merge(mem_rdata, req_word, req_wdata, req_wstrb);
            end else begin
                data_array[req_index] <= mem_rdata;
                cpu_rdata             <= load_extract(mem_rdata, req_word,
                                                      req_addr[1:0], req_size);
            end
        end
    end

endmodule

// File: hw/line_memory.sv
`include "cache_consts.svh"

module line_memory #(
    parameter int LATENCY = `MEM_LATENCY
) (
    input  logic                clk,
    input  logic                rstn,

    input  logic                mem_req,
    input  logic                mem_we,
    input  cache_pkg::addr_t    mem_addr,
    input  cache_pkg::line_t    mem_wdata,
    output logic                mem_busy,
    output logic                mem_rvalid,
    output cache_pkg::line_t    mem_rdata
);

    localparam int OFFSET_BITS = $clog2(`CACHE_LINE_BYTES);
    localparam int MEM_IDX_BITS = $clog2(`MEM_N_LINES);
    localparam int CNT_BITS = $clog2(LATENCY + 1);

    cache_pkg::line_t           mem_array [`MEM_N_LINES];

    logic [MEM_IDX_BITS-1:0]    req_idx;
    logic [MEM_IDX_BITS-1:0]    line_sel;   // Line of the access in progress
    logic [CNT_BITS-1:0]        cnt;
    logic                       rd_op;
    logic                       accept;
    logic                       finish;

    // Upper address bits wrap
    assign req_idx = mem_addr[OFFSET_BITS +: MEM_IDX_BITS];

    assign accept = mem_req && !mem_busy;
    assign finish = mem_busy && (cnt == '0);

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            mem_busy   <= 1'b0;
            mem_rvalid <= 1'b0;
            cnt        <= '0;
            rd_op      <= 1'b0;
            line_sel   <= '0;
            for (int i = 0; i < `MEM_N_LINES; i++) begin
                mem_array[i] <= '0;
            end
        end else begin
            mem_rvalid <= 1'b0;
            if (accept) begin
                mem_busy <= 1'b1;
                cnt      <= CNT_BITS'(LATENCY - 1);
                rd_op    <= !mem_we;
                line_sel <= req_idx;
                if (mem_we) begin
                    mem_array[req_idx] <= mem_wdata; // Write lands at acceptance
                end
            end else if (finish) begin
                mem_busy   <= 1'b0;
                mem_rvalid <= rd_op;
            end else if (mem_busy) begin
                cnt <= cnt - 1'b1;
            end
        end
    end

    // Read data presented with the rvalid pulse
    always_ff @(posedge clk) begin
        if (finish && rd_op) begin
            mem_rdata <= mem_array[line_sel];
        end
    end

endmodule

// File: hw/cache_pkg.sv
`include "cache_consts.svh"

package cache_pkg;

    // Byte address
    typedef logic [`CACHE_ADDR_WIDTH-1:0] addr_t;

    // CPU data word and its byte strobes
    typedef logic [31:0] word_t;
    typedef logic [3:0]  strb_t;

    // Access-size code as in the SIZE_* macros
    typedef logic [1:0] size_t;

    // One whole cache line
    typedef logic [`CACHE_LINE_BYTES*8-1:0] line_t;

    // Tag sits above index, index above offset
    typedef logic [$clog2(`CACHE_N_LINES)-1:0] index_t;
    typedef logic [`CACHE_ADDR_WIDTH-$clog2(`CACHE_LINE_BYTES)-$clog2(`CACHE_N_LINES)-1:0] tag_t;

    typedef enum logic [1:0] {
        CS_IDLE,       // Waiting for a CPU request
        CS_LOOKUP,     // Tag compare and hit service
        CS_WRITEBACK,  // Dirty victim going out
        CS_REFILL      // Line coming in
    } cache_state_e;

endpackage

// File: hw/cache_consts.svh
`ifndef CACHE_CONSTS_SVH
`define CACHE_CONSTS_SVH

// Byte address width of the CPU and memory ports
`define CACHE_ADDR_WIDTH 32

// Cache geometry
`define CACHE_LINE_BYTES 16
`define CACHE_N_LINES    4

// Backing line memory wraps addresses modulo its depth
`define MEM_N_LINES      64
`define MEM_LATENCY      3

// Access-size codes on cpu_size
`define SIZE_BYTE        2'd0
`define SIZE_HALF        2'd1
`define SIZE_WORD        2'd2

`endif
